// ==== design/edp_settings.svh ====
`ifndef EDP_SETTINGS_SVH
`define EDP_SETTINGS_SVH

// Data word width
// Bit 0 is the most significant bit everywhere
`define EDP_WORD_BITS 36

// Fast memory geometry
`define EDP_FM_WORDS 16
`define EDP_FM_ADDR_BITS 4

// Microword number field
// Also the width of the magic constant fed to ADX
`define EDP_MAGIC_BITS 9

`endif

// ==== design/edpPkg.sv ====
`include "edp_settings.svh"

package edpPkg;

  typedef logic [0:`EDP_WORD_BITS-1] tWord;

  // Adder functions
  // Subtract is A plus inverted B with the chain carry-in forced
  typedef enum logic [2:0] {
    adAdd,
    adSub,
    adAnd,
    adOr,
    adXor,
    adPassA,
    adPassB
  } tAdFunc;

  typedef enum logic [1:0] {adaAr, adaArx, adaMq, adaZero} tAdaSel;

  // Same order as the B operand patterns of the EBOX
  typedef enum logic [1:0] {adbFm, adbBrx2, adbBr, adbArx4} tAdbSel;

  typedef enum logic [2:0] {
    arHold,
    arZero,
    arCache,
    arBus,
    arAd,
    arAdx,
    arAdShl
  } tArSel;

  // MQ universal shift register
  typedef enum logic [1:0] {usrLoad, usrShl, usrShr, usrHold} tUsrFunc;

  typedef enum logic [2:0] {
    diagAr,
    diagBr,
    diagMq,
    diagFm,
    diagBrx,
    diagArx,
    diagAdx,
    diagAd
  } tDiagSel;

  typedef struct packed {
    logic diagRead;
    tDiagSel diagSel;
    logic [4:0] spare;
  } tDiagNumber;

  // Number field, read as magic or as a diagnostic request
  typedef union packed {
    logic [0:`EDP_MAGIC_BITS-1] magic;
    tDiagNumber diag;
  } tNumber;

  typedef struct packed {
    tAdFunc adFunc;
    tAdaSel adaSel;
    tAdbSel adbSel;
    logic carryIn;
    logic longAdd;
    tArSel arSel;
    tArSel arxSel;
    tUsrFunc mqFunc;
    logic brLoad;
    logic brxLoad;
    logic [`EDP_FM_ADDR_BITS-1:0] fmAddr;
    logic fmWriteL;
    logic fmWriteR;
    logic numberIsDiag;
    tNumber number;
  } tMicroWord;

  typedef struct packed {
    tAdFunc adFunc;
    tAdaSel adaSel;
    tAdbSel adbSel;
    logic carryIn;
    logic longAdd;
    tArSel arSel;
    tArSel arxSel;
    tUsrFunc mqFunc;
    logic brLoad;
    logic brxLoad;
    logic [`EDP_FM_ADDR_BITS-1:0] fmAddr;
    logic fmWriteL;
    logic fmWriteR;
    logic numberIsDiag;
    logic [0:`EDP_MAGIC_BITS-1] magic;
    logic diagRead;
    tDiagSel diagSel;
    logic mqFromAd;
  } tControl;

  typedef struct packed {
    tWord ar;
    tWord arx;
    tWord br;
    tWord brx;
    tWord mq;
  } tRegs;

  typedef struct packed {
    tWord ad;
    tWord adx;
    logic adCarryOut;
  } tAdResult;

endpackage

// ==== design/edpControl.sv ====
`timescale 1ns/1ps

module edpControl (
  input  logic              CLK,
  input  logic              arstN,
  input  edpPkg::tMicroWord microWord,
  input  logic              microStrobe,
  output edpPkg::tControl   ctl
);

  edpPkg::tMicroWord wordReg;
  logic wordValid;

  // Microword holding register
  always_ff @(posedge CLK) begin
    if (microStrobe) begin
      wordReg <= microWord;
    end
  end

  // Strobe becomes a one-cycle valid
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      wordValid <= 1'b0;
    end else begin
      wordValid <= microStrobe;
    end
  end

  always_comb begin
    // Idle word holds everything
    ctl = '0;
    ctl.arSel = edpPkg::arHold;
    ctl.arxSel = edpPkg::arHold;
    ctl.mqFunc = edpPkg::usrHold;
    if (wordValid) begin
      ctl.adFunc = wordReg.adFunc;
      ctl.adaSel = wordReg.adaSel;
      ctl.adbSel = wordReg.adbSel;
      ctl.carryIn = wordReg.carryIn;
      ctl.longAdd = wordReg.longAdd;
      ctl.arSel = wordReg.arSel;
      ctl.arxSel = wordReg.arxSel;
      ctl.mqFunc = wordReg.mqFunc;
      ctl.brLoad = wordReg.brLoad;
      ctl.brxLoad = wordReg.brxLoad;
      ctl.fmAddr = wordReg.fmAddr;
      ctl.fmWriteL = wordReg.fmWriteL;
      ctl.fmWriteR = wordReg.fmWriteR;
      ctl.numberIsDiag = wordReg.numberIsDiag;
      if (wordReg.numberIsDiag) begin
        ctl.diagRead = wordReg.number.diag.diagRead;
        ctl.diagSel = wordReg.number.diag.diagSel;
      end else begin
        // Magic view never requests a readback
        ctl.magic = wordReg.number.magic;
      end
      ctl.mqFromAd = (wordReg.adaSel == edpPkg::adaMq);
    end
  end

endmodule

// ==== design/edpAdder.sv ====
`timescale 1ns/1ps
`include "edp_settings.svh"

module edpAdder (
  input  edpPkg::tControl   ctl,
  input  edpPkg::tRegs      regs,
  input  edpPkg::tWord      fm,
  output edpPkg::tAdResult  adResult
);

  edpPkg::tWord adA;
  edpPkg::tWord adB;
  edpPkg::tWord adxB;
  logic lowCarryIn;
  logic adCarryIn;
  logic [`EDP_WORD_BITS:0] adSum;
  logic [`EDP_WORD_BITS:0] adxSum;

  // One 36-bit slice, carry-out on top
  function automatic logic [`EDP_WORD_BITS:0] evalWord(
    edpPkg::tAdFunc func,
    edpPkg::tWord a,
    edpPkg::tWord b,
    logic cin
  );
    logic [`EDP_WORD_BITS:0] result;
    case (func)
      edpPkg::adAdd: result = {1'b0, a} + {1'b0, b} + cin;
      edpPkg::adSub: result = {1'b0, a} + {1'b0, ~b} + cin;
      edpPkg::adAnd: result = {1'b0, a & b};
      edpPkg::adOr: result = {1'b0, a | b};
      edpPkg::adXor: result = {1'b0, a ^ b};
      edpPkg::adPassB: result = {1'b0, b};
      default: result = {1'b0, a};
    endcase
    return result;
  endfunction

  always_comb begin
    unique case (ctl.adaSel)
      edpPkg::adaAr: adA = regs.ar;
      edpPkg::adaArx: adA = regs.arx;
      edpPkg::adaMq: adA = regs.mq;
      default: adA = '0;
    endcase
  end

  // B operands, doubled and quadrupled words shift across from the low word
  always_comb begin
    unique case (ctl.adbSel)
      edpPkg::adbFm: begin
        adB = fm;
        adxB = {ctl.magic, {(`EDP_WORD_BITS - `EDP_MAGIC_BITS){1'b0}}};
      end
      edpPkg::adbBrx2: begin
        adB = {regs.br[1:35], regs.brx[0]};
        adxB = {regs.brx[1:35], 1'b0};
      end
      edpPkg::adbBr: begin
        adB = regs.br;
        adxB = regs.brx;
      end
      default: begin
        adB = {regs.ar[2:35], regs.arx[0:1]};
        adxB = {regs.arx[2:35], 2'b00};
      end
    endcase
  end

  // The plus one of subtract enters at the bottom of the chain
  assign lowCarryIn = (ctl.adFunc == edpPkg::adSub) ? 1'b1 : ctl.carryIn;
  assign adxSum = evalWord(ctl.adFunc, regs.arx, adxB, lowCarryIn);
  assign adCarryIn = ctl.longAdd ? adxSum[`EDP_WORD_BITS] : lowCarryIn;
  assign adSum = evalWord(ctl.adFunc, adA, adB, adCarryIn);

  assign adResult.ad = adSum[`EDP_WORD_BITS-1:0];
  assign adResult.adx = adxSum[`EDP_WORD_BITS-1:0];
  assign adResult.adCarryOut = adSum[`EDP_WORD_BITS];

endmodule

// ==== design/edpRegisters.sv ====
`timescale 1ns/1ps

module edpRegisters (
  input  logic              CLK,
  input  logic              arstN,
  input  edpPkg::tControl   ctl,
  input  edpPkg::tAdResult  adResult,
  input  edpPkg::tWord      cacheData,
  input  edpPkg::tWord      ebusIn,
  output edpPkg::tRegs      regs
);

  edpPkg::tWord arNext;
  edpPkg::tWord arxNext;
  edpPkg::tWord mqNext;
  edpPkg::tWord mqLoad;

  // Shared source mux for AR and ARX
  function automatic edpPkg::tWord pickSource(
    edpPkg::tArSel sel,
    edpPkg::tWord oldValue,
    edpPkg::tWord cache,
    edpPkg::tWord bus,
    edpPkg::tAdResult alu
  );
    edpPkg::tWord value;
    case (sel)
      edpPkg::arZero: value = '0;
      edpPkg::arCache: value = cache;
      edpPkg::arBus: value = bus;
      edpPkg::arAd: value = alu.ad;
      edpPkg::arAdx: value = alu.adx;
      // AD times two, low bit from ADX
      edpPkg::arAdShl: value = {alu.ad[1:35], alu.adx[0]};
      default: value = oldValue;
    endcase
    return value;
  endfunction

  assign arNext = pickSource(ctl.arSel, regs.ar, cacheData, ebusIn, adResult);
  assign arxNext = pickSource(ctl.arxSel, regs.arx, cacheData, ebusIn, adResult);

  assign mqLoad = ctl.mqFromAd ? adResult.ad : adResult.adx;

  // MQ universal shift register
  always_comb begin
    unique case (ctl.mqFunc)
      edpPkg::usrLoad: mqNext = mqLoad;
      edpPkg::usrShl: mqNext = {regs.mq[1:35], adResult.adCarryOut};
      edpPkg::usrShr: mqNext = {regs.mq[0], regs.mq[0:34]};
      default: mqNext = regs.mq;
    endcase
  end

  // All loads sample the old register values
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      regs <= '0;
    end else begin
      regs.ar <= arNext;
      regs.arx <= arxNext;
      regs.mq <= mqNext;
      if (ctl.brLoad) begin
        regs.br <= regs.ar;
      end
      if (ctl.brxLoad) begin
        regs.brx <= regs.arx;
      end
    end
  end

endmodule

// ==== design/edpFastMem.sv ====
`timescale 1ns/1ps
`include "edp_settings.svh"

module edpFastMem (
  input  logic            CLK,
  input  edpPkg::tControl ctl,
  input  edpPkg::tWord    ar,
  output edpPkg::tWord    fm,
  output logic            fmParity
);

  localparam int HalfBits = `EDP_WORD_BITS / 2;

  edpPkg::tWord mem [0:`EDP_FM_WORDS-1];

  // Left and right halves written separately
  always_ff @(posedge CLK) begin
    if (ctl.fmWriteL) begin
      mem[ctl.fmAddr][0:HalfBits-1] <= ar[0:HalfBits-1];
    end
    if (ctl.fmWriteR) begin
      mem[ctl.fmAddr][HalfBits:`EDP_WORD_BITS-1] <= ar[HalfBits:`EDP_WORD_BITS-1];
    end
  end

  // Asynchronous read port
  assign fm = mem[ctl.fmAddr];
  assign fmParity = ^fm;

endmodule

// ==== design/edpEbusDriver.sv ====
`timescale 1ns/1ps

module edpEbusDriver (
  input  logic              CLK,
  input  logic              arstN,
  input  edpPkg::tControl   ctl,
  input  edpPkg::tRegs      regs,
  input  edpPkg::tWord      fm,
  input  edpPkg::tAdResult  adResult,
  output edpPkg::tWord      ebusData,
  output logic              ebusDriving
);

  edpPkg::tWord diagWord;

  always_comb begin
    unique case (ctl.diagSel)
      edpPkg::diagAr: diagWord = regs.ar;
      edpPkg::diagBr: diagWord = regs.br;
      edpPkg::diagMq: diagWord = regs.mq;
      edpPkg::diagFm: diagWord = fm;
      edpPkg::diagBrx: diagWord = regs.brx;
      edpPkg::diagArx: diagWord = regs.arx;
      edpPkg::diagAdx: diagWord = adResult.adx;
      default: diagWord = adResult.ad;
    endcase
  end

  // Bus is zero whenever not driving
  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      ebusDriving <= 1'b0;
      ebusData <= '0;
    end else begin
      ebusDriving <= ctl.diagRead;
      ebusData <= ctl.diagRead ? diagWord : '0;
    end
  end

endmodule

// ==== design/edpTop.sv ====
`timescale 1ns/1ps

module edpTop (
  input  logic              CLK,
  input  logic              arstN,
  input  edpPkg::tMicroWord microWord,
  input  logic              microStrobe,
  input  edpPkg::tWord      cacheData,
  input  edpPkg::tWord      ebusIn,
  output edpPkg::tWord      ebusData,
  output logic              ebusDriving,
  output logic              fmParity
);

  edpPkg::tControl ctl;
  edpPkg::tRegs regs;
  edpPkg::tAdResult adResult;
  edpPkg::tWord fm;

  edpControl i_edpControl (
    .CLK         (CLK),
    .arstN       (arstN),
    .microWord   (microWord),
    .microStrobe (microStrobe),
    .ctl         (ctl)
  );

  edpAdder i_edpAdder (
    .ctl      (ctl),
    .regs     (regs),
    .fm       (fm),
    .adResult (adResult)
  );

  edpRegisters i_edpRegisters (
    .CLK       (CLK),
    .arstN     (arstN),
    .ctl       (ctl),
    .adResult  (adResult),
    .cacheData (cacheData),
    .ebusIn    (ebusIn),
    .regs      (regs)
  );

  // Fast memory takes its write data from AR
  edpFastMem i_edpFastMem (
    .CLK      (CLK),
    .ctl      (ctl),
    .ar       (regs.ar),
    .fm       (fm),
    .fmParity (fmParity)
  );

  edpEbusDriver i_edpEbusDriver (
    .CLK         (CLK),
    .arstN       (arstN),
    .ctl         (ctl),
    .regs        (regs),
    .fm          (fm),
    .adResult    (adResult),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

endmodule

// ==== bench/edpClockGen.sv ====
`timescale 1ns/1ps

module edpClockGen (
  output logic CLK,
  output logic arstN
);

  localparam real HalfPeriod = 4.0;
  localparam int ResetCycles = 10;

  initial begin
    CLK = 1'b0;
    forever #(HalfPeriod) CLK = ~CLK;
  end

  // Release just after an edge, like the other inputs
  initial begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge CLK);
    #1 arstN = 1'b1;
  end

endmodule

// ==== bench/edpTb.sv ====
`timescale 1ns/1ps
`include "edp_settings.svh"

module edpTb;

  localparam int ResetCycles = 10;
  localparam int CyclesPerWord = 40;
  localparam int HalfBits = `EDP_WORD_BITS / 2;

  logic CLK;
  logic arstN;
  edpPkg::tMicroWord microWord;
  logic microStrobe;
  edpPkg::tWord cacheData;
  edpPkg::tWord ebusIn;
  edpPkg::tWord ebusData;
  logic ebusDriving;
  logic fmParity;

  // Shadow copy of the datapath state
  edpPkg::tWord mAr;
  edpPkg::tWord mArx;
  edpPkg::tWord mBr;
  edpPkg::tWord mBrx;
  edpPkg::tWord mMq;
  edpPkg::tWord mFm [0:`EDP_FM_WORDS-1];
  logic [0:`EDP_FM_WORDS-1] fmLeftKnown;
  logic [0:`EDP_FM_WORDS-1] fmRightKnown;

  // Expectation for the word being driven, then delayed to its checking edge
  logic slotDrive;
  edpPkg::tWord slotData;
  logic slotParCheck;
  logic slotPar;
  logic driveStage1;
  logic driveStage2;
  edpPkg::tWord dataStage1;
  edpPkg::tWord dataStage2;
  logic parCheckStage;
  logic parStage;

  int errorCount = 0;
  int errorsAtStart = 0;
  int testCount = 0;
  int wordsIssued = 0;
  int cycleCount = 0;

  edpClockGen clockGen (
    .CLK   (CLK),
    .arstN (arstN)
  );

  edpTop i_edpTop (
    .CLK         (CLK),
    .arstN       (arstN),
    .microWord   (microWord),
    .microStrobe (microStrobe),
    .cacheData   (cacheData),
    .ebusIn      (ebusIn),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving),
    .fmParity    (fmParity)
  );

  always_ff @(posedge CLK or negedge arstN) begin
    if (!arstN) begin
      driveStage1 <= 1'b0;
      driveStage2 <= 1'b0;
      dataStage1 <= '0;
      dataStage2 <= '0;
      parCheckStage <= 1'b0;
      parStage <= 1'b0;
    end else begin
      driveStage1 <= slotDrive;
      driveStage2 <= driveStage1;
      dataStage1 <= slotData;
      dataStage2 <= dataStage1;
      parCheckStage <= slotParCheck;
      parStage <= slotPar;
    end
  end

  always @(posedge CLK) cycleCount++;

  busDrivingCheck: assert property (@(posedge CLK) disable iff (!arstN)
    ebusDriving == driveStage2)
  else begin
    errorCount++;
    $display("FAIL ebusDriving got %h expected %h", $sampled(ebusDriving),
             $sampled(driveStage2));
  end

  busDataCheck: assert property (@(posedge CLK) disable iff (!arstN)
    ebusData == dataStage2)
  else begin
    errorCount++;
    $display("FAIL ebusData got %h expected %h", $sampled(ebusData), $sampled(dataStage2));
  end

  // Parity is valid only while the addressed word is fully known
  fmParityCheck: assert property (@(posedge CLK) disable iff (!arstN)
    parCheckStage |-> (fmParity == parStage))
  else begin
    errorCount++;
    $display("FAIL fmParity got %h expected %h", $sampled(fmParity), $sampled(parStage));
  end

  function automatic edpPkg::tWord randWord();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[`EDP_WORD_BITS-1:0];
  endfunction

  // One adder word with its carry-out
  function automatic edpPkg::tWord aluWord(
    input edpPkg::tAdFunc func,
    input edpPkg::tWord a,
    input edpPkg::tWord b,
    input logic cin,
    output logic cout
  );
    logic [`EDP_WORD_BITS:0] sum;
    edpPkg::tWord notB;
    notB = ~b;
    sum = '0;
    case (func)
      edpPkg::adAdd: sum = a + b + cin;
      edpPkg::adSub: sum = a + notB + cin;
      edpPkg::adAnd: sum[`EDP_WORD_BITS-1:0] = a & b;
      edpPkg::adOr: sum[`EDP_WORD_BITS-1:0] = a | b;
      edpPkg::adXor: sum[`EDP_WORD_BITS-1:0] = a ^ b;
      edpPkg::adPassB: sum[`EDP_WORD_BITS-1:0] = b;
      default: sum[`EDP_WORD_BITS-1:0] = a;
    endcase
    cout = sum[`EDP_WORD_BITS];
    return sum[`EDP_WORD_BITS-1:0];
  endfunction

  function automatic edpPkg::tWord nextReg(
    input edpPkg::tArSel sel,
    input edpPkg::tWord old,
    input edpPkg::tWord cache,
    input edpPkg::tWord bus,
    input edpPkg::tWord ad,
    input edpPkg::tWord adx
  );
    logic [0:2*`EDP_WORD_BITS-1] pair;
    edpPkg::tWord result;
    pair = {ad, adx} << 1;
    case (sel)
      edpPkg::arZero: result = '0;
      edpPkg::arCache: result = cache;
      edpPkg::arBus: result = bus;
      edpPkg::arAd: result = ad;
      edpPkg::arAdx: result = adx;
      edpPkg::arAdShl: result = pair[0:`EDP_WORD_BITS-1];
      default: result = old;
    endcase
    return result;
  endfunction

  // All fields idle, diagnostic view with no read
  function automatic edpPkg::tMicroWord blankWord();
    edpPkg::tMicroWord w;
    w = '0;
    w.adFunc = edpPkg::adPassA;
    w.adaSel = edpPkg::adaZero;
    w.adbSel = edpPkg::adbBr;
    w.arSel = edpPkg::arHold;
    w.arxSel = edpPkg::arHold;
    w.mqFunc = edpPkg::usrHold;
    w.numberIsDiag = 1'b1;
    return w;
  endfunction

  // Strobes one word and steps the shadow model in issue order
  task automatic issue(input edpPkg::tMicroWord w, input edpPkg::tWord cache,
                       input edpPkg::tWord bus);
    edpPkg::tWord opA;
    edpPkg::tWord opB;
    edpPkg::tWord opBx;
    edpPkg::tWord fmWord;
    edpPkg::tWord magicWord;
    edpPkg::tWord ad;
    edpPkg::tWord adx;
    edpPkg::tWord readback;
    edpPkg::tWord newAr;
    edpPkg::tWord newArx;
    logic [0:2*`EDP_WORD_BITS-1] pair;
    logic lowCin;
    logic adxCout;
    logic adCout;
    case (w.adaSel)
      edpPkg::adaAr: opA = mAr;
      edpPkg::adaArx: opA = mArx;
      edpPkg::adaMq: opA = mMq;
      default: opA = '0;
    endcase
    fmWord = mFm[w.fmAddr];
    magicWord = '0;
    if (!w.numberIsDiag) begin
      magicWord[0:`EDP_MAGIC_BITS-1] = w.number.magic;
    end
    pair = '0;
    case (w.adbSel)
      edpPkg::adbFm: pair = {fmWord, magicWord};
      edpPkg::adbBrx2: pair = {mBr, mBrx} << 1;
      edpPkg::adbBr: pair = {mBr, mBrx};
      default: pair = {mAr, mArx} << 2;
    endcase
    opB = pair[0:`EDP_WORD_BITS-1];
    opBx = pair[`EDP_WORD_BITS:2*`EDP_WORD_BITS-1];
    lowCin = (w.adFunc == edpPkg::adSub) | w.carryIn;
    adx = aluWord(w.adFunc, mArx, opBx, lowCin, adxCout);
    ad = aluWord(w.adFunc, opA, opB, w.longAdd ? adxCout : lowCin, adCout);

    slotDrive = w.numberIsDiag && w.number.diag.diagRead;
    readback = '0;
    if (slotDrive) begin
      case (w.number.diag.diagSel)
        edpPkg::diagAr: readback = mAr;
        edpPkg::diagBr: readback = mBr;
        edpPkg::diagMq: readback = mMq;
        edpPkg::diagFm: readback = fmWord;
        edpPkg::diagBrx: readback = mBrx;
        edpPkg::diagArx: readback = mArx;
        edpPkg::diagAdx: readback = adx;
        default: readback = ad;
      endcase
    end
    slotData = readback;
    slotParCheck = fmLeftKnown[w.fmAddr] && fmRightKnown[w.fmAddr];
    slotPar = ^fmWord;

    // State updates, each from the old values
    if (w.fmWriteL) begin
      mFm[w.fmAddr][0:HalfBits-1] = mAr[0:HalfBits-1];
      fmLeftKnown[w.fmAddr] = 1'b1;
    end
    if (w.fmWriteR) begin
      mFm[w.fmAddr][HalfBits:`EDP_WORD_BITS-1] = mAr[HalfBits:`EDP_WORD_BITS-1];
      fmRightKnown[w.fmAddr] = 1'b1;
    end
    case (w.mqFunc)
      edpPkg::usrLoad: mMq = (w.adaSel == edpPkg::adaMq) ? ad : adx;
      edpPkg::usrShl: mMq = {mMq[1:`EDP_WORD_BITS-1], adCout};
      edpPkg::usrShr: mMq = {mMq[0], mMq[0:`EDP_WORD_BITS-2]};
      default: mMq = mMq;
    endcase
    if (w.brLoad) begin
      mBr = mAr;
    end
    if (w.brxLoad) begin
      mBrx = mArx;
    end
    newAr = nextReg(w.arSel, mAr, cache, bus, ad, adx);
    newArx = nextReg(w.arxSel, mArx, cache, bus, ad, adx);
    mAr = newAr;
    mArx = newArx;

    microWord = w;
    microStrobe = 1'b1;
    wordsIssued++;
    @(posedge CLK);
    #1;
    // Load data is needed during the decode cycle
    microStrobe = 1'b0;
    cacheData = cache;
    ebusIn = bus;
    slotDrive = 1'b0;
    slotData = '0;
    slotParCheck = 1'b0;
  endtask

  task automatic readBack(input edpPkg::tDiagSel sel, input int addr);
    edpPkg::tMicroWord w;
    w = blankWord();
    w.fmAddr = addr;
    w.number.diag.diagRead = 1'b1;
    w.number.diag.diagSel = sel;
    issue(w, '0, '0);
  endtask

  task automatic loadArArx(input edpPkg::tWord cache, input edpPkg::tWord bus);
    edpPkg::tMicroWord w;
    w = blankWord();
    w.arSel = edpPkg::arCache;
    w.arxSel = edpPkg::arBus;
    issue(w, cache, bus);
  endtask

  task automatic copyToBrBrx();
    edpPkg::tMicroWord w;
    w = blankWord();
    w.brLoad = 1'b1;
    w.brxLoad = 1'b1;
    issue(w, '0, '0);
  endtask

  task automatic mqStep(input edpPkg::tUsrFunc func, input edpPkg::tAdaSel ada,
                        input edpPkg::tAdFunc adFunc);
    edpPkg::tMicroWord w;
    w = blankWord();
    w.mqFunc = func;
    w.adaSel = ada;
    w.adFunc = adFunc;
    w.carryIn = $urandom_range(1, 0);
    issue(w, '0, '0);
    readBack(edpPkg::diagMq, 0);
  endtask

  task automatic finishTest(input string name);
    // Let the last readback reach its checking edge
    repeat (3) @(posedge CLK);
    #1;
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %0d %s: pass", testCount, name);
    end else begin
      $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsAtStart);
    end
    errorsAtStart = errorCount;
  endtask

  initial begin : watchdog
    while (cycleCount <= ResetCycles + CyclesPerWord * (wordsIssued + 1)) begin
      @(posedge CLK);
    end
    $display("Timeout after %0d cycles with %0d microwords issued", cycleCount, wordsIssued);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    edpPkg::tMicroWord w;
    int i;
    int f;
    int a;
    void'($urandom(73405));
    microWord = '0;
    microStrobe = 1'b0;
    cacheData = '0;
    ebusIn = '0;
    slotDrive = 1'b0;
    slotData = '0;
    slotParCheck = 1'b0;
    slotPar = 1'b0;
    mAr = '0;
    mArx = '0;
    mBr = '0;
    mBrx = '0;
    mMq = '0;
    fmLeftKnown = '0;
    fmRightKnown = '0;
    wait (arstN === 1'b1);
    @(posedge CLK);
    #1;

    repeat (3) @(posedge CLK);
    #1;
    readBack(edpPkg::diagAr, 0);
    readBack(edpPkg::diagArx, 0);
    readBack(edpPkg::diagBr, 0);
    readBack(edpPkg::diagBrx, 0);
    readBack(edpPkg::diagMq, 0);
    finishTest("reset readback");

    for (i = 0; i < 4; i++) begin
      loadArArx(randWord(), randWord());
      copyToBrBrx();
      loadArArx(randWord(), randWord());
      for (f = 0; f <= 6; f++) begin
        w = blankWord();
        w.adFunc = edpPkg::tAdFunc'(f);
        w.adaSel = edpPkg::tAdaSel'($urandom_range(3, 0));
        w.adbSel = edpPkg::tAdbSel'($urandom_range(3, 1));
        w.carryIn = $urandom_range(1, 0);
        w.number.diag.diagRead = 1'b1;
        w.number.diag.diagSel = edpPkg::diagAd;
        issue(w, '0, '0);
        w.number.diag.diagSel = edpPkg::diagAdx;
        issue(w, '0, '0);
      end
    end
    finishTest("adder functions");

    // First pass forces a carry out of ADX
    for (i = 0; i < 9; i++) begin
      loadArArx(randWord(), (i == 0) ? 36'h000000001 : randWord());
      copyToBrBrx();
      loadArArx(randWord(), (i == 0) ? '1 : randWord());
      w = blankWord();
      w.adFunc = (i % 3 == 2) ? edpPkg::adSub : edpPkg::adAdd;
      w.adaSel = edpPkg::adaAr;
      w.adbSel = edpPkg::adbBr;
      w.longAdd = 1'b1;
      w.carryIn = $urandom_range(1, 0);
      w.arSel = edpPkg::arAd;
      w.arxSel = edpPkg::arAdx;
      w.number.diag.diagRead = 1'b1;
      w.number.diag.diagSel = edpPkg::diagAd;
      issue(w, '0, '0);
      readBack(edpPkg::diagAr, 0);
      readBack(edpPkg::diagArx, 0);
    end
    finishTest("long add");

    for (a = 0; a < `EDP_FM_WORDS; a++) begin
      w = blankWord();
      w.arSel = edpPkg::arCache;
      w.fmAddr = a;
      w.fmWriteL = 1'b1;
      w.fmWriteR = 1'b1;
      issue(w, randWord(), '0);
      w.fmWriteR = 1'b0;
      issue(w, randWord(), '0);
      readBack(edpPkg::diagFm, a);
      w.fmWriteL = 1'b0;
      w.fmWriteR = 1'b1;
      issue(w, randWord(), '0);
      readBack(edpPkg::diagFm, a);
    end
    // Magic constant on ADX and a fast memory operand on AD
    for (i = 0; i < 4; i++) begin
      w = blankWord();
      w.numberIsDiag = 1'b0;
      w.number.magic = $urandom_range(511, 0);
      w.adFunc = edpPkg::adAdd;
      w.adaSel = edpPkg::adaAr;
      w.adbSel = edpPkg::adbFm;
      w.fmAddr = $urandom_range(`EDP_FM_WORDS - 1, 0);
      w.arSel = edpPkg::arAd;
      w.arxSel = edpPkg::arAdx;
      issue(w, '0, '0);
      readBack(edpPkg::diagAr, 0);
      readBack(edpPkg::diagArx, 0);
    end
    finishTest("fast memory");

    for (i = 0; i < 6; i++) begin
      loadArArx(randWord(), randWord());
      copyToBrBrx();
      loadArArx(randWord(), randWord());
      mqStep(edpPkg::usrLoad, edpPkg::adaMq, edpPkg::tAdFunc'($urandom_range(6, 0)));
      mqStep(edpPkg::usrLoad, edpPkg::adaAr, edpPkg::adAdd);
      mqStep(edpPkg::usrShl, edpPkg::adaAr, edpPkg::adAdd);
      mqStep(edpPkg::usrShr, edpPkg::adaArx, edpPkg::adAdd);
      mqStep(edpPkg::usrHold, edpPkg::adaAr, edpPkg::adSub);
    end
    finishTest("mq shifts");

    for (i = 0; i < 12; i++) begin
      repeat ($urandom_range(4, 1)) begin
        w = blankWord();
        w.adFunc = edpPkg::tAdFunc'($urandom_range(6, 0));
        w.adaSel = edpPkg::tAdaSel'($urandom_range(3, 0));
        w.adbSel = edpPkg::tAdbSel'($urandom_range(3, 0));
        w.carryIn = $urandom_range(1, 0);
        w.longAdd = $urandom_range(1, 0);
        w.fmAddr = $urandom_range(`EDP_FM_WORDS - 1, 0);
        w.number.diag.diagRead = 1'b1;
        w.number.diag.diagSel = edpPkg::tDiagSel'($urandom_range(7, 0));
        issue(w, '0, '0);
      end
      repeat ($urandom_range(2, 1)) @(posedge CLK);
      #1;
    end
    finishTest("back-to-back readback");

    $display("%0d tests, %0d microwords, %0d failed checks", testCount, wordsIssued,
             errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+design
design/edpPkg.sv
design/edpControl.sv
design/edpAdder.sv
design/edpRegisters.sv
design/edpFastMem.sv
design/edpEbusDriver.sv
design/edpTop.sv
bench/edpClockGen.sv
bench/edpTb.sv
